// File: common/rtg_pkg.sv
//////////////////////////////////////////////////
// Shared types for the RTG video path
// Video word, RGB, sync and display settings
// Default FIFO depth and OSD tint values
//////////////////////////////////////////////////

`default_nettype none

package rtg_pkg;

	//////////////////////////////////////////////////
	// Pixel and sync types
	//////////////////////////////////////////////////

	// Hi-colour word as fetched from memory
	typedef struct packed {
		logic       flag;       // Unused in hi-colour mode
		logic [4:0] r;          // Red 14:10
		logic [4:0] g;          // Green 9:5
		logic [4:0] b;          // Blue 4:0
	} rtg_word_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		logic hs;               // Horizontal sync level
		logic vs;               // Vertical sync level
		logic cs;               // Composite sync level
	} sync_t;

	// Display settings, static during a frame
	typedef struct packed {
		logic       ena;        // RTG screen on
		logic [3:0] pixel_width; // Clocks per fetch minus one
		logic [6:0] vbend;      // Extra vblank lines
		logic       ext;        // Extend active area one clock
	} rtg_cfg_t;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	localparam int RTG_FIFO_DEPTH_DEF = 16;  // Words

	// OSD tint, pixel set
	localparam logic [1:0] OSD_PIX_R = 2'b11;
	localparam logic [1:0] OSD_PIX_G = 2'b11;
	localparam logic [1:0] OSD_PIX_B = 2'b11;
	// OSD tint, background, a dark blue
	localparam logic [1:0] OSD_BG_R  = 2'b00;
	localparam logic [1:0] OSD_BG_G  = 2'b00;
	localparam logic [1:0] OSD_BG_B  = 2'b10;

endpackage

`default_nettype wire

// File: rtg/rtg_word_fifo.sv
//////////////////////////////////////////////////
// Show-ahead FIFO of RTG video words
// Valid/ready fill port, pop strobe, flush
// Underflow flag for pops on an empty FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtg_word_fifo #(
	parameter int depth = 16
) (
	input  logic              CLK_114,
	input  logic              rst,
	input  logic              flush,
	input  logic              fill_valid,
	input  rtg_pkg::rtg_word_t fill_data,
	output logic              fill_ready,
	input  logic              pop,
	output rtg_pkg::rtg_word_t head,
	output logic              head_valid,
	output logic              underflow
);
	import rtg_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);
	localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
	localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

	rtg_word_t        mem [depth];      // Word storage
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;            // Occupancy
	logic             push_ok;
	logic             pop_ok;

	assign fill_ready = (count != full_cnt);   // Not full
	assign head_valid = (count != '0);
	assign head       = mem[rd_ptr];           // Show-ahead read

	assign push_ok = fill_valid && fill_ready && !flush;  // Dropped while flushing
	assign pop_ok  = pop && head_valid && !flush;

	// Storage write
	always_ff @(posedge CLK_114) begin
		if (push_ok)
			mem[wr_ptr] <= fill_data;
	end

	//////////////////////////////////////////////////
	// Pointers and count
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst || flush) begin
			wr_ptr <= '0;                  // Empty in one clock
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

	// Pop found nothing, flag it for one clock
	always_ff @(posedge CLK_114) begin
		if (rst)
			underflow <= 1'b0;
		else
			underflow <= pop && !head_valid;
	end

endmodule

`default_nettype wire

// File: rtg/rtg_blank_gen.sv
//////////////////////////////////////////////////
// RTG blanking generator
// Stretches vblank by a number of hsync lines
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtg_blank_gen (
	input  logic       CLK_114,
	input  logic       rst,
	input  logic       hblank,
	input  logic       vblank,
	input  logic       hs,
	input  logic [6:0] vbend,
	output logic       blank
);

	logic       vflag;          // Stretched vertical blank
	logic [6:0] line_cnt;       // Lines since vblank fell
	logic       hs_d;
	logic       hs_rise;

	assign hs_rise = hs && !hs_d;   // Rising hsync edge

	always_ff @(posedge CLK_114) begin
		if (rst)
			hs_d <= 1'b0;
		else
			hs_d <= hs;
	end

	// Chipset vblank is too short for RTG modes,
	// so hold the flag for vbend more lines
	always_ff @(posedge CLK_114) begin
		if (rst) begin
			vflag    <= 1'b0;
			line_cnt <= '0;
		end else if (vblank) begin
			vflag    <= 1'b1;       // Restart stretch
			line_cnt <= '0;
		end else if (line_cnt == vbend) begin
			vflag    <= 1'b0;       // Stretch done, counter parks
		end else if (hs_rise) begin
			line_cnt <= line_cnt + 1'b1;
		end
	end

	assign blank = vflag | hblank;  // Combined blank

endmodule

`default_nettype wire

// File: rtg/rtg_fetch_timer.sv
//////////////////////////////////////////////////
// RTG pixel fetch timer
// Divides the clock per pixel, strobes fetch
// Optional one-clock active area extension
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtg_fetch_timer (
	input  logic             CLK_114,
	input  logic             rst,
	input  rtg_pkg::rtg_cfg_t cfg,
	input  logic             blank,
	output logic             fetch
);

	logic [3:0] pix_cnt;        // Compared against pixel_width
	logic       blank_d;        // Blank one clock ago
	logic       blank_rise;
	logic       active;

	assign blank_rise = blank && !blank_d;
	assign active     = !blank || (cfg.ext && blank_rise);  // Extension pops once more

	// Fetch strobe
	assign fetch = cfg.ena && active && (pix_cnt == cfg.pixel_width);

	always_ff @(posedge CLK_114) begin
		if (rst)
			blank_d <= 1'b0;
		else
			blank_d <= blank;
	end

	// Divider, restarted by blank
	always_ff @(posedge CLK_114) begin
		if (rst)
			pix_cnt <= '0;
		else if (blank || fetch)
			pix_cnt <= '0;
		else
			pix_cnt <= pix_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/video_out_mux.sv
//////////////////////////////////////////////////
// Video output stage
// Hi-colour expansion, RTG or native select
// OSD tint and output registers
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module video_out_mux (
	input  logic              CLK_114,
	input  logic              rst,
	input  logic              rtg_ena,
	input  logic              blank,
	input  rtg_pkg::rtg_word_t head,
	input  logic              head_valid,
	input  rtg_pkg::rgb_t     native_rgb,
	input  rtg_pkg::sync_t    native_sync,
	input  logic              osd_window,
	input  logic              osd_pixel,
	output rtg_pkg::rgb_t     vga_rgb,
	output rtg_pkg::sync_t    vga_sync
);
	import rtg_pkg::*;

	rgb_t       rtg_rgb;        // Expanded hi-colour
	rgb_t       pick_rgb;       // After RTG or native select
	rgb_t       osd_rgb;        // After OSD tint
	logic       use_rtg;
	logic [1:0] tint_r;
	logic [1:0] tint_g;
	logic [1:0] tint_b;

	//////////////////////////////////////////////////
	// Hi-colour expansion and source select
	//////////////////////////////////////////////////

	// Top three bits repeat below the five
	assign rtg_rgb.r = {head.r, head.r[4:2]};
	assign rtg_rgb.g = {head.g, head.g[4:2]};
	assign rtg_rgb.b = {head.b, head.b[4:2]};

	assign use_rtg  = rtg_ena && !blank && head_valid;
	assign pick_rgb = use_rtg ? rtg_rgb : native_rgb;

	//////////////////////////////////////////////////
	// OSD tint
	//////////////////////////////////////////////////

	assign tint_r = osd_pixel ? OSD_PIX_R : OSD_BG_R;
	assign tint_g = osd_pixel ? OSD_PIX_G : OSD_BG_G;
	assign tint_b = osd_pixel ? OSD_PIX_B : OSD_BG_B;

	always_comb begin
		osd_rgb = pick_rgb;
		if (osd_window) begin
			osd_rgb.r = {tint_r, pick_rgb.r[7:2]};  // Tint over dimmed picture
			osd_rgb.g = {tint_g, pick_rgb.g[7:2]};
			osd_rgb.b = {tint_b, pick_rgb.b[7:2]};
		end
	end

	// Output registers, no stall
	always_ff @(posedge CLK_114) begin
		if (rst) begin
			vga_rgb  <= '0;
			vga_sync <= '0;
		end else begin
			vga_rgb  <= osd_rgb;
			vga_sync <= native_sync;   // Sync keeps pace with colour
		end
	end

endmodule

`default_nettype wire

// File: verilog/rtg_video_top.sv
//////////////////////////////////////////////////
// RTG video pipeline top level
// FIFO, blank generator, fetch timer, output mux
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtg_video_top #(
	parameter int fifo_depth = rtg_pkg::RTG_FIFO_DEPTH_DEF
) (
	input  logic              CLK_114,
	input  logic              rst,
	// Memory side
	input  logic              fill_valid,
	input  rtg_pkg::rtg_word_t fill_data,
	output logic              fill_ready,
	// Chipset side
	input  rtg_pkg::rgb_t     native_rgb,
	input  rtg_pkg::sync_t    native_sync,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              osd_window,
	input  logic              osd_pixel,
	input  rtg_pkg::rtg_cfg_t cfg,
	// Display side
	output rtg_pkg::rgb_t     vga_rgb,
	output rtg_pkg::sync_t    vga_sync,
	output logic              underflow
);
	import rtg_pkg::*;

	logic      blank;           // Combined RTG blank
	logic      fetch;           // Word pop strobe
	logic      flush;
	rtg_word_t head;            // Word on show
	logic      head_valid;

	assign flush = vblank || !cfg.ena;  // Restart the stream each frame

	//////////////////////////////////////////////////
	// Pipeline stages
	//////////////////////////////////////////////////

	rtg_word_fifo #(.depth(fifo_depth)) u_fifo (
		.CLK_114    (CLK_114),
		.rst        (rst),
		.flush      (flush),
		.fill_valid (fill_valid),
		.fill_data  (fill_data),
		.fill_ready (fill_ready),
		.pop        (fetch),
		.head       (head),
		.head_valid (head_valid),
		.underflow  (underflow)
	);

	rtg_blank_gen u_blank (
		.CLK_114 (CLK_114),
		.rst     (rst),
		.hblank  (hblank),
		.vblank  (vblank),
		.hs      (native_sync.hs),   // Lines counted on hsync
		.vbend   (cfg.vbend),
		.blank   (blank)
	);

	rtg_fetch_timer u_timer (
		.CLK_114 (CLK_114),
		.rst     (rst),
		.cfg     (cfg),
		.blank   (blank),
		.fetch   (fetch)
	);

	video_out_mux u_mux (
		.CLK_114     (CLK_114),
		.rst         (rst),
		.rtg_ena     (cfg.ena),
		.blank       (blank),
		.head        (head),
		.head_valid  (head_valid),
		.native_rgb  (native_rgb),
		.native_sync (native_sync),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.vga_rgb     (vga_rgb),
		.vga_sync    (vga_sync)
	);

endmodule

`default_nettype wire

// File: tests/rtg_video_chk.sv
//////////////////////////////////////////////////
// FIFO handshake assertions, bound into
// rtg_word_fifo
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtg_video_chk #(
	parameter int depth = 16
) (
	input  logic               CLK_114,
	input  logic               rst,
	input  logic               fill_valid,
	input  logic               fill_ready,
	input  rtg_pkg::rtg_word_t fill_data,
	input  logic               pop,
	input  logic               head_valid,
	input  logic               underflow,
	input  logic [31:0]        count
);

	// Full FIFO never takes a further word
	a_no_overflow: assert property (@(posedge CLK_114) disable iff (rst)
		count <= depth)
		else $error("FIFO occupancy above depth");

	// Empty pop is flagged and leaves the FIFO empty
	a_empty_pop: assert property (@(posedge CLK_114) disable iff (rst)
		(pop && !head_valid && !fill_valid) |=> (underflow && !head_valid))
		else $error("pop on an empty FIFO not flagged or not ignored");

	// Stalled word held by the source
	a_word_held: assert property (@(posedge CLK_114) disable iff (rst)
		(fill_valid && !fill_ready) |=> (fill_valid && $stable(fill_data)))
		else $error("fill word changed while stalled");

endmodule

bind rtg_word_fifo rtg_video_chk #(.depth(depth)) u_chk (
	.CLK_114    (CLK_114),
	.rst        (rst),
	.fill_valid (fill_valid),
	.fill_ready (fill_ready),
	.fill_data  (fill_data),
	.pop        (pop),
	.head_valid (head_valid),
	.underflow  (underflow),
	.count      (32'(count))
);

`default_nettype wire

// File: tests/tb_rtg_video.sv
//////////////////////////////////////////////////
// Testbench for the RTG video pipeline
// Clock, reset, xorshift stimulus, check task
// Directed tests, timeout and summary
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rtg_video;
	import rtg_pkg::*;

	localparam int max_cycles = 3000;   // Run limit in clocks

	logic      CLK_114;
	logic      rst;
	logic      fill_valid;
	rtg_word_t fill_data;
	logic      fill_ready;
	rgb_t      native_rgb;
	sync_t     native_sync;
	logic      hblank;
	logic      vblank;
	logic      osd_window;
	logic      osd_pixel;
	rtg_cfg_t  cfg;
	rgb_t      vga_rgb;
	sync_t     vga_sync;
	logic      underflow;

	logic [31:0] rng;                   // Xorshift state
	int          errors;
	int          checks;
	int          tests;
	int          cycles;
	string       test_name;
	int          test_err0;
	rtg_word_t   words [16];

	rtg_video_top UUT (
		.CLK_114     (CLK_114),
		.rst         (rst),
		.fill_valid  (fill_valid),
		.fill_data   (fill_data),
		.fill_ready  (fill_ready),
		.native_rgb  (native_rgb),
		.native_sync (native_sync),
		.hblank      (hblank),
		.vblank      (vblank),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.cfg         (cfg),
		.vga_rgb     (vga_rgb),
		.vga_sync    (vga_sync),
		.underflow   (underflow)
	);

	initial begin
		CLK_114 = 1'b0;
		forever #4 CLK_114 = ~CLK_114;  // 8 ns period
	end

	// Run limit
	always @(posedge CLK_114) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Top three bits repeated below the five
	function automatic rgb_t expand(input rtg_word_t w);
		rgb_t c;
		c.r = {w.r, w.r[4:2]};
		c.g = {w.g, w.g[4:2]};
		c.b = {w.b, w.b[4:2]};
		return c;
	endfunction

	task automatic check(input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch in %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s done, %0d errors", test_name, errors - test_err0);
	endtask

	// Offer one word and hold it until accepted
	task automatic push_word(input rtg_word_t w);
		int n;
		n = 0;
		@(posedge CLK_114);
		fill_valid <= 1'b1;
		fill_data  <= w;
		@(negedge CLK_114);
		while (!fill_ready && n < 50) begin
			@(negedge CLK_114);
			n++;
		end
		if (n >= 50) begin
			errors++;
			$display("%s: word never accepted, fill_ready stayed low", test_name);
		end
		@(posedge CLK_114);             // Handshake edge
		fill_valid <= 1'b0;
	endtask

	task automatic set_cfg(input logic ena, input logic [3:0] pw, input logic [6:0] vbe);
		@(posedge CLK_114);
		cfg    <= {ena, pw, vbe, 1'b0}; // No extension
		hblank <= 1'b1;                 // Hold off fetches
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	// Native passthrough or OSD tint on native when osd is set
	task automatic native_path(input string name, input logic osd);
		rgb_t  prev_rgb;
		sync_t prev_sync;
		logic  prev_pix;
		begin_test(name);
		set_cfg(1'b0, 4'd0, 7'd0);
		for (int i = 0; i < 12; i++) begin
			@(posedge CLK_114);
			rng = xorshift(rng);
			native_rgb  <= rng[23:0];
			native_sync <= rng[26:24];
			osd_window  <= osd;
			osd_pixel   <= rng[27];
			@(negedge CLK_114);
			if (i > 1 && !osd) begin
				check(prev_rgb, vga_rgb);
				check(prev_sync, vga_sync);
			end else if (i > 1) begin
				check({prev_pix ? 2'b11 : 2'b00, prev_rgb.r[7:2]}, vga_rgb.r);
				check({prev_pix ? 2'b11 : 2'b00, prev_rgb.g[7:2]}, vga_rgb.g);
				check({prev_pix ? 2'b11 : 2'b10, prev_rgb.b[7:2]}, vga_rgb.b);
			end
			prev_rgb  = native_rgb;     // Values now on the inputs
			prev_sync = native_sync;
			prev_pix  = osd_pixel;
		end
		@(posedge CLK_114);
		osd_window <= 1'b0;
		end_test();
	endtask

	// Push n words in blank then show each for pw+1 cycles
	task automatic word_stream(input string name, input int n, input logic [3:0] pw);
		begin_test(name);
		set_cfg(1'b1, pw, 7'd0);
		@(posedge CLK_114);
		native_rgb <= '0;
		for (int i = 0; i < n; i++) begin
			rng = xorshift(rng);
			words[i] = rng[15:0];
			push_word(words[i]);
		end
		@(posedge CLK_114);
		hblank <= 1'b0;                 // First active clock
		@(negedge CLK_114);
		for (int k = 0; k < n * (pw + 1); k++) begin
			@(negedge CLK_114);
			check(expand(words[k / (pw + 1)]), vga_rgb);
		end
		end_test();
	endtask

	task automatic vblank_stretch();
		int n;
		begin_test("vblank_stretch");
		@(posedge CLK_114);
		cfg         <= {1'b1, 4'd0, 7'd3, 1'b0};  // RTG on, three extra lines
		hblank      <= 1'b0;
		vblank      <= 1'b1;
		native_rgb  <= '0;
		native_sync <= '0;
		@(posedge CLK_114);
		vblank <= 1'b0;
		for (int i = 0; i < 2; i++) begin
			rng = xorshift(rng);
			words[i] = rng[15:0] | 16'h0001;  // Never black
			push_word(words[i]);
		end
		for (int p = 0; p < 2; p++) begin
			@(posedge CLK_114);
			native_sync.hs <= 1'b1;
			@(posedge CLK_114);
			native_sync.hs <= 1'b0;
			@(negedge CLK_114);
			check(24'h0, vga_rgb);      // Still blanked
		end
		@(posedge CLK_114);
		native_sync.hs <= 1'b1;         // Third line edge
		@(posedge CLK_114);
		native_sync.hs <= 1'b0;
		n = 1;
		do begin
			@(negedge CLK_114);
			n++;
		end while (vga_rgb == '0 && n < 20);
		check(4, n);
		check(expand(words[0]), vga_rgb);
		@(negedge CLK_114);
		check(expand(words[1]), vga_rgb);
		end_test();
	endtask

	task automatic backpressure_flush();
		int n;
		begin_test("backpressure_flush");
		set_cfg(1'b1, 4'd0, 7'd0);
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			push_word(rng[15:0]);
		end
		@(posedge CLK_114);
		rng = xorshift(rng);
		fill_valid <= 1'b1;             // Seventeenth word waits
		fill_data  <= rng[15:0];
		@(negedge CLK_114);
		check(1'b0, fill_ready);
		@(posedge CLK_114);
		hblank <= 1'b0;                 // One active clock gives one fetch
		@(posedge CLK_114);
		hblank <= 1'b1;
		@(negedge CLK_114);
		check(1'b1, fill_ready);
		@(posedge CLK_114);
		fill_valid <= 1'b0;
		vblank     <= 1'b1;             // Flush
		rng = xorshift(rng);
		native_rgb <= rng[23:0];
		@(posedge CLK_114);
		vblank <= 1'b0;
		repeat (2) @(posedge CLK_114);
		hblank <= 1'b0;
		n = 0;
		do begin
			@(negedge CLK_114);
			n++;
		end while (!underflow && n < 10);
		if (!underflow) begin
			errors++;
			$display("%s: underflow never pulsed on an empty FIFO", test_name);
		end
		check(native_rgb, vga_rgb);
		end_test();
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		rng         = 32'h4a25;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		cycles      = 0;
		rst         = 1'b1;
		fill_valid  = 1'b0;
		fill_data   = '0;
		native_rgb  = '0;
		native_sync = '0;
		hblank      = 1'b0;
		vblank      = 1'b0;
		osd_window  = 1'b0;
		osd_pixel   = 1'b0;
		cfg         = '0;
		repeat (2) @(posedge CLK_114);
		rst <= 1'b0;
		native_path("native_passthrough", 1'b0);
		word_stream("hicolour_expand", 8, 4'd0);
		word_stream("pixel_width", 3, 4'd3);
		vblank_stretch();
		native_path("osd_tint", 1'b1);
		backpressure_flush();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
common/rtg_pkg.sv
rtg/rtg_word_fifo.sv
rtg/rtg_blank_gen.sv
rtg/rtg_fetch_timer.sv
verilog/video_out_mux.sv
verilog/rtg_video_top.sv
tests/rtg_video_chk.sv
tests/tb_rtg_video.sv
